// ==== sim.f ====
+incdir+tb
rtl/video_pkg.sv
rtl/store_wr_if.sv
rtl/video_timing.sv
rtl/frame_capture.sv
rtl/frame_store.sv
rtl/display_fetch.sv
rtl/frame_ctrl.sv
rtl/video_out.sv
rtl/frame_display_top.sv
tb/tb_frame_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run the frame display testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_frame_display -f sim.f -o tb_sim \
   > build.log 2>&1 \
   && ./obj_dir/tb_sim > sim.log 2>&1
grep -q "TB PASSED" sim.log \
   && echo "simulation ok" \
   || { echo "simulation did not pass, see build.log and sim.log"; exit 1; }

// ==== tb/tb_checks.svh ====
// random bit source, typed compare tasks and bounded wait tasks
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////
// random source
////////////////////////////////////////

// 16-bit galois step, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
   return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// one lfsr step per bit taken
task automatic draw_bits(input int n, output logic [7:0] val);
   val = '0;
   for (int i = 0; i < n; i++) begin
      val = {val[6:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
   end
endtask

function automatic video_pkg::phase_e shown_phase(input logic s);
   if (s) begin
      return video_pkg::show;
   end
   return video_pkg::capture;
endfunction

////////////////////////////////////////
// compares
////////////////////////////////////////

task automatic check_pix(input string name, input video_pkg::pix_t exp,
                         input video_pkg::pix_t got);
   if (got !== exp) begin
      stop_with_failure($sformatf("Error: %s expected %h got %h", name, exp, got));
   end
endtask

task automatic check_bit(input string name, input logic exp, input logic got);
   if (got !== exp) begin
      stop_with_failure($sformatf("Error: %s expected %h got %h", name, exp, got));
   end
endtask

task automatic check_phase(input string name, input video_pkg::phase_e exp,
                           input video_pkg::phase_e got);
   if (got !== exp) begin
      stop_with_failure($sformatf("Error: %s expected %h got %h", name, exp, got));
   end
endtask

////////////////////////////////////////
// bounded waits
////////////////////////////////////////

// returns at the negedge before the accepting edge
task automatic hold_until_accepted(input int limit);
   int n;
   n = 0;
   @(negedge clk);
   while (!in_ready) begin
      check_bit("showing", 1'b0, showing);
      if (n >= limit) begin
         stop_with_failure("pixel offered but never accepted");
      end
      @(negedge clk);
      n++;
   end
   // frame not complete until this pixel is in
   check_bit("showing", 1'b0, showing);
endtask

task automatic await_showing(input logic exp, input int limit);
   int n;
   n = 0;
   @(negedge clk);
   while (showing !== exp) begin
      if (n >= limit) begin
         stop_with_failure($sformatf("showing did not become %0b in time", exp));
      end
      @(negedge clk);
      n++;
   end
endtask

// vsync rising edge, the start of the output frame
task automatic sync_to_frame_start(input int limit);
   logic last;
   logic done;
   int n;
   n = 0;
   done = 1'b0;
   @(negedge clk);
   last = vsync;
   while (!done) begin
      @(negedge clk);
      n++;
      if (vsync && !last) begin
         done = 1'b1;
      end else if (n > limit) begin
         stop_with_failure("no vsync rising edge within the timeout");
      end
      last = vsync;
   end
endtask

`endif

// ==== tb/tb_frame_display.sv ====
// testbench top with clock, reset, stimulus table loop, raster tracking, reference frame and DUT
`timescale 1ns/1ps

module tb_frame_display;

   // geometry handed to the DUT
   // porches stay at their default of 2
   localparam int H_ACTIVE = 32;
   localparam int H_SYNC = 4;
   localparam int H_TOTAL = H_ACTIVE + 2 + H_SYNC + 2;
   localparam int V_ACTIVE = 24;
   localparam int V_SYNC = 2;
   localparam int V_TOTAL = V_ACTIVE + 2 + V_SYNC + 2;
   localparam int IMG_W = 16;
   localparam int IMG_H = 8;
   localparam int X_OFF = 4;
   localparam int Y_OFF = 2;
   localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
   localparam int N_STEPS = 9;

   typedef enum logic [2:0] {
      op_send_frame,
      op_send_part,
      op_stall,
      op_recapture,
      op_check_display
   } op_e;

   // one table row holds an operation, its count and the phase expected afterwards
   typedef struct {
      op_e op;
      int arg;
      video_pkg::phase_e phase;
   } step_t;

   logic clk, rst_n, in_valid, in_sof, recapture;
   video_pkg::pix_t in_data;
   logic in_ready, hsync, vsync, blank, showing;
   video_pkg::pix_t pix_out;

   step_t steps [N_STEPS];
   // reference frame filled in acceptance order
   video_pkg::pix_t ref_frame [IMG_W*IMG_H];
   video_pkg::store_addr_t wr_addr;
   logic [15:0] lfsr_state;
   video_pkg::phase_e exp_phase;
   logic disp_check_on, row_valid;
   logic prev_hsync, prev_vsync, prev_blank;
   logic h_seen, v_seen;
   int row, col, win_count;
   int h_period, h_low, v_period, v_low;

   `include "tb_checks.svh"

   frame_display_top #(
      .H_ACTIVE(H_ACTIVE), .H_SYNC(H_SYNC), .V_ACTIVE(V_ACTIVE), .V_SYNC(V_SYNC),
      .IMG_W(IMG_W), .IMG_H(IMG_H), .X_OFF(X_OFF), .Y_OFF(Y_OFF)
   ) UUT (
      .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_data(in_data),
      .in_sof(in_sof), .recapture(recapture), .in_ready(in_ready),
      .pix_out(pix_out), .hsync(hsync), .vsync(vsync), .blank(blank),
      .showing(showing)
   );

   // 40 ns period
   always #20 clk = ~clk;

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1);
   endtask

   function automatic logic in_window(input int r, input int c);
      return (c >= X_OFF) && (c < X_OFF + IMG_W) && (r >= Y_OFF) && (r < Y_OFF + IMG_H);
   endfunction

   // luma expected at an output position in the current phase
   function automatic video_pkg::pix_t expected_pixel(input int r, input int c);
      if (exp_phase != video_pkg::show) begin
         return video_pkg::BLACK_LEVEL;
      end
      if (in_window(r, c)) begin
         return ref_frame[video_pkg::store_addr_t'((r - Y_OFF) * IMG_W + c - X_OFF)];
      end
      return video_pkg::BG_LEVEL;
   endfunction

   // offers n pixels with random gaps, sof on the first
   task automatic send_pixels(input int n);
      logic [7:0] gap;
      logic [7:0] data;
      for (int i = 0; i < n; i++) begin
         draw_bits(2, gap);
         repeat (gap) begin
            @(posedge clk);
            #2;
         end
         draw_bits(8, data);
         in_valid = 1'b1;
         in_data = data;
         in_sof = (i == 0);
         hold_until_accepted(64);
         @(posedge clk);
         #2;
         in_valid = 1'b0;
         in_sof = 1'b0;
         // sof restarts the address
         wr_addr = (i == 0) ? '0 : wr_addr + 1'b1;
         ref_frame[wr_addr] = data;
      end
   endtask

   ////////////////////////////////////////
   // output monitor
   ////////////////////////////////////////

   always @(negedge clk) begin
      if (rst_n) begin
         // first blank fall after a vsync rise is row 0
         if (vsync && !prev_vsync) begin
            row = -1;
            row_valid = 1'b1;
         end
         if (!blank && prev_blank) begin
            row++;
            col = 0;
         end else if (!blank) begin
            col++;
         end
         if (blank) begin
            check_pix("pix_out", video_pkg::BLACK_LEVEL, pix_out);
         end else if (disp_check_on && row_valid) begin
            check_phase("phase", exp_phase, shown_phase(showing));
            check_pix("pix_out", expected_pixel(row, col), pix_out);
            if (in_window(row, col)) begin
               win_count++;
            end
         end
         // sync widths and periods
         h_period++;
         v_period++;
         if (!hsync) h_low++;
         if (!vsync) v_low++;
         if (!hsync && prev_hsync) begin
            if (h_seen && h_period != H_TOTAL) begin
               stop_with_failure($sformatf("hsync period of %0d clocks", h_period));
            end
            h_seen = 1'b1;
            h_period = 0;
         end
         if (hsync && !prev_hsync) begin
            if (h_low != H_SYNC) begin
               stop_with_failure($sformatf("hsync low for %0d clocks", h_low));
            end
            h_low = 0;
         end
         if (!vsync && prev_vsync) begin
            if (v_seen && v_period != FRAME_CLKS) begin
               stop_with_failure($sformatf("vsync period of %0d clocks", v_period));
            end
            v_seen = 1'b1;
            v_period = 0;
         end
         if (vsync && !prev_vsync) begin
            if (v_low != V_SYNC * H_TOTAL) begin
               stop_with_failure($sformatf("vsync low for %0d clocks", v_low));
            end
            v_low = 0;
         end
         prev_hsync = hsync;
         prev_vsync = vsync;
         prev_blank = blank;
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      in_valid = 1'b0;
      in_data = '0;
      in_sof = 1'b0;
      recapture = 1'b0;
      lfsr_state = 16'd25;
      wr_addr = '0;
      exp_phase = video_pkg::capture;
      disp_check_on = 1'b0;
      row_valid = 1'b0;
      prev_hsync = 1'b1;
      prev_vsync = 1'b1;
      prev_blank = 1'b1;
      h_seen = 1'b0;
      v_seen = 1'b0;
      row = 0;
      col = 0;
      win_count = 0;
      h_period = 0;
      h_low = 0;
      v_period = 0;
      v_low = 0;
      steps[0] = '{op_send_frame, 128, video_pkg::show};
      steps[1] = '{op_check_display, 0, video_pkg::show};
      steps[2] = '{op_stall, 50, video_pkg::show};
      steps[3] = '{op_recapture, 0, video_pkg::capture};
      steps[4] = '{op_check_display, 0, video_pkg::capture};
      // partial frame whose addressing the next sof restarts
      steps[5] = '{op_send_part, 40, video_pkg::capture};
      steps[6] = '{op_stall, 20, video_pkg::capture};
      steps[7] = '{op_send_frame, 128, video_pkg::show};
      steps[8] = '{op_check_display, 0, video_pkg::show};

      // reset state seen in the last reset cycle
      repeat (4) @(posedge clk);
      @(negedge clk);
      check_bit("hsync", 1'b1, hsync);
      check_bit("vsync", 1'b1, vsync);
      check_bit("blank", 1'b1, blank);
      check_pix("pix_out", video_pkg::BLACK_LEVEL, pix_out);
      check_bit("showing", 1'b0, showing);
      @(posedge clk);
      #2;
      rst_n = 1'b1;

      for (int s = 0; s < N_STEPS; s++) begin
         case (steps[s].op)
            op_send_frame: begin
               send_pixels(steps[s].arg);
               await_showing(1'b1, 64);
            end
            op_send_part: begin
               send_pixels(steps[s].arg);
            end
            op_stall: begin
               repeat (steps[s].arg) begin
                  @(negedge clk);
                  check_phase("phase", steps[s].phase, shown_phase(showing));
                  // capture is closed while showing
                  if (steps[s].phase == video_pkg::show) begin
                     check_bit("in_ready", 1'b0, in_ready);
                  end
               end
            end
            op_recapture: begin
               recapture = 1'b1;
               @(posedge clk);
               #2;
               recapture = 1'b0;
               await_showing(1'b0, 4);
            end
            default: begin
               // one whole frame between two vsync rises
               exp_phase = steps[s].phase;
               sync_to_frame_start(2 * FRAME_CLKS);
               win_count = 0;
               disp_check_on = 1'b1;
               sync_to_frame_start(2 * FRAME_CLKS);
               disp_check_on = 1'b0;
               if (win_count != IMG_W * IMG_H) begin
                  stop_with_failure($sformatf("only %0d window pixels checked", win_count));
               end
            end
         endcase
         @(posedge clk);
         #2;
      end

      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== rtl/frame_display_top.sv ====
// frame buffer display top: timing, capture, store, fetch, control, output
`timescale 1ns/1ps

module frame_display_top #(
   parameter int H_ACTIVE = 32,
   parameter int H_FRONT = 2,
   parameter int H_SYNC = 4,
   parameter int H_BACK = 2,
   parameter int V_ACTIVE = 24,
   parameter int V_FRONT = 2,
   parameter int V_SYNC = 2,
   parameter int V_BACK = 2,
   parameter int IMG_W = 16,
   parameter int IMG_H = 8,
   parameter int X_OFF = 4,
   parameter int Y_OFF = 2
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            in_valid,
   input  video_pkg::pix_t in_data,
   input  logic            in_sof,
   input  logic            recapture,
   output logic            in_ready,
   output video_pkg::pix_t pix_out,
   output logic            hsync,
   output logic            vsync,
   output logic            blank,
   output logic            showing
);

   // counter widths, same as inside the timing generator
   localparam int H_W = $clog2(H_ACTIVE + H_FRONT + H_SYNC + H_BACK);
   localparam int V_W = $clog2(V_ACTIVE + V_FRONT + V_SYNC + V_BACK);

   logic [H_W-1:0] hcount;
   logic [V_W-1:0] vcount;
   logic hsync_raw, vsync_raw, blank_raw;
   logic rd_en;
   video_pkg::store_addr_t rd_addr;
   video_pkg::pix_t rd_data;
   video_pkg::phase_e phase;
   logic capture_en, frame_done;

   // capture to store write channel
   store_wr_if wr_bus ();

   ////////////////////////////////////////
   // raster
   ////////////////////////////////////////

   video_timing #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
   ) u_timing (
      .clk(clk), .rst_n(rst_n), .hcount(hcount), .vcount(vcount),
      .hsync(hsync_raw), .vsync(vsync_raw), .blank(blank_raw)
   );

   ////////////////////////////////////////
   // capture path
   ////////////////////////////////////////

   frame_capture #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_capture (
      .clk(clk), .rst_n(rst_n), .capture_en(capture_en),
      .in_valid(in_valid), .in_data(in_data), .in_sof(in_sof),
      .in_ready(in_ready), .frame_done(frame_done), .wr(wr_bus.writer)
   );

   frame_store #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_store (
      .clk(clk), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
      .wr(wr_bus.store)
   );

   frame_ctrl u_ctrl (
      .clk(clk), .rst_n(rst_n), .frame_done(frame_done), .recapture(recapture),
      .phase(phase), .capture_en(capture_en), .showing(showing)
   );

   ////////////////////////////////////////
   // display path
   ////////////////////////////////////////

   display_fetch #(
      .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .H_W(H_W), .V_W(V_W),
      .IMG_W(IMG_W), .IMG_H(IMG_H), .X_OFF(X_OFF), .Y_OFF(Y_OFF)
   ) u_fetch (
      .clk(clk), .rst_n(rst_n), .hcount(hcount), .vcount(vcount), .phase(phase),
      .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data), .pix(pix_out)
   );

   // syncs delayed to meet pix_out
   video_out u_out (
      .clk(clk), .rst_n(rst_n),
      .hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .blank_raw(blank_raw),
      .hsync(hsync), .vsync(vsync), .blank(blank)
   );

endmodule

// ==== rtl/video_out.sv ====
// sync and blank delay line matched to the pixel fetch latency
`timescale 1ns/1ps

module video_out (
   input  logic clk,
   input  logic rst_n,
   input  logic hsync_raw,
   input  logic vsync_raw,
   input  logic blank_raw,
   output logic hsync,
   output logic vsync,
   output logic blank
);

   localparam int DEPTH = video_pkg::FETCH_LAT;

   // {hsync, vsync, blank} per stage
   logic [2:0] sync_d [DEPTH];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // syncs idle high, display blanked
         for (int i = 0; i < DEPTH; i++) begin
            sync_d[i] <= 3'b111;
         end
      end else begin
         sync_d[0] <= {hsync_raw, vsync_raw, blank_raw};
         for (int i = 1; i < DEPTH; i++) begin
            sync_d[i] <= sync_d[i-1];
         end
      end
   end

   // now in step with the registered pixel
   assign hsync = sync_d[DEPTH-1][2];
   assign vsync = sync_d[DEPTH-1][1];
   assign blank = sync_d[DEPTH-1][0];

endmodule

// ==== rtl/frame_ctrl.sv ====
// capture and show phase FSM
`timescale 1ns/1ps

module frame_ctrl (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              frame_done,
   input  logic              recapture,
   output video_pkg::phase_e phase,
   output logic              capture_en,
   output logic              showing
);

   video_pkg::phase_e phase_nxt;

   ////////////////////////////////////////
   // transitions
   ////////////////////////////////////////

   always_comb begin
      phase_nxt = phase;
      case (phase)
         video_pkg::capture: begin
            // last store write accepted
            if (frame_done) begin
               phase_nxt = video_pkg::show;
            end
         end
         video_pkg::show: begin
            if (recapture) begin
               phase_nxt = video_pkg::capture;
            end
         end
         default: begin
            phase_nxt = video_pkg::capture;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase <= video_pkg::capture;
      end else begin
         phase <= phase_nxt;
      end
   end

   // decoded phase outputs
   assign capture_en = (phase == video_pkg::capture);
   assign showing    = (phase == video_pkg::show);

endmodule

// ==== rtl/display_fetch.sv ====
// raster to store address mapping and window or background pixel select
`timescale 1ns/1ps

module display_fetch #(
   parameter int H_ACTIVE = 32,
   parameter int V_ACTIVE = 24,
   parameter int H_W = 6,
   parameter int V_W = 5,
   parameter int IMG_W = 16,
   parameter int IMG_H = 8,
   parameter int X_OFF = 4,
   parameter int Y_OFF = 2
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [H_W-1:0]         hcount,
   input  logic [V_W-1:0]         vcount,
   input  video_pkg::phase_e      phase,
   output logic                   rd_en,
   output video_pkg::store_addr_t rd_addr,
   input  video_pkg::pix_t        rd_data,
   output video_pkg::pix_t        pix
);

   // index of the flag stage that meets the store data
   localparam int LAST = video_pkg::FETCH_LAT - 2;

   logic [H_W-1:0] win_x;
   logic [V_W-1:0] win_y;
   logic active, in_win;
   // {active, in_win} travelling alongside the read
   logic [1:0] flag_d [video_pkg::FETCH_LAT-1];

   // window-relative position, only meaningful when in_win is set
   assign win_x = hcount - H_W'(X_OFF);
   assign win_y = vcount - V_W'(Y_OFF);

   assign active = (hcount < H_W'(H_ACTIVE)) && (vcount < V_W'(V_ACTIVE));
   assign in_win = (hcount >= H_W'(X_OFF)) && (hcount < H_W'(X_OFF + IMG_W)) &&
                   (vcount >= V_W'(Y_OFF)) && (vcount < V_W'(Y_OFF + IMG_H));

   // reads run in both phases so capture sees the same stall pattern
   assign rd_en   = in_win;
   assign rd_addr = video_pkg::store_addr_t'(win_y * IMG_W + win_x);

   ////////////////////////////////////////
   // select register
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i <= LAST; i++) begin
            flag_d[i] <= '0;
         end
         pix <= video_pkg::BLACK_LEVEL;
      end else begin
         flag_d[0] <= {active, in_win};
         for (int i = 1; i <= LAST; i++) begin
            flag_d[i] <= flag_d[i-1];
         end
         if ((phase != video_pkg::show) || !flag_d[LAST][1]) begin
            pix <= video_pkg::BLACK_LEVEL;
         end else if (flag_d[LAST][0]) begin
            pix <= rd_data;
         end else begin
            pix <= video_pkg::BG_LEVEL;
         end
      end
   end

endmodule

// ==== rtl/frame_store.sv ====
// single-port frame store with display read priority over capture writes
`timescale 1ns/1ps

module frame_store #(
   parameter int IMG_W = 16,
   parameter int IMG_H = 8
) (
   input  logic                   clk,
   input  logic                   rd_en,
   input  video_pkg::store_addr_t rd_addr,
   output video_pkg::pix_t        rd_data,
   store_wr_if.store              wr
);

   localparam int DEPTH = IMG_W * IMG_H;

   // one word per window pixel
   video_pkg::pix_t mem [DEPTH];

   // the raster never waits
   // a read owns the port and the writer is held off for that cycle
   assign wr.ready = !rd_en;

   ////////////////////////////////////////
   // port access
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      // registered read, data valid one clock after rd_en
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
      if (wr.valid && wr.ready) begin
         mem[wr.addr] <= wr.data;
      end
   end

endmodule

// ==== rtl/frame_capture.sv ====
// capture of the input pixel stream into sequential frame store writes
`timescale 1ns/1ps

module frame_capture #(
   parameter int IMG_W = 16,
   parameter int IMG_H = 8
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              capture_en,
   input  logic              in_valid,
   input  video_pkg::pix_t   in_data,
   input  logic              in_sof,
   output logic              in_ready,
   output logic              frame_done,
   store_wr_if.writer        wr
);

   localparam video_pkg::store_addr_t LAST_ADDR =
      video_pkg::store_addr_t'(IMG_W * IMG_H - 1);

   // set by the first sof after capture starts
   logic synced;
   logic take, keep, wr_fire, last_held;
   video_pkg::store_addr_t next_addr;

   assign wr_fire   = wr.valid && wr.ready;
   // the final pixel of a frame stalls the input until it is written,
   // so nothing slips into the store after the frame completes
   assign last_held = wr.valid && (wr.addr == LAST_ADDR);
   assign in_ready  = capture_en && (!wr.valid || (wr.ready && !last_held));
   assign take      = in_valid && in_ready;
   // pixels before the first sof are consumed and dropped
   assign keep      = take && (synced || in_sof);
   assign frame_done = wr_fire && (wr.addr == LAST_ADDR);

   ////////////////////////////////////////
   // control
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr.valid  <= 1'b0;
         synced    <= 1'b0;
         next_addr <= '0;
      end else begin
         if (keep) begin
            wr.valid <= 1'b1;
         end else if (wr_fire) begin
            wr.valid <= 1'b0;
         end
         if (!capture_en) begin
            synced <= 1'b0;
         end else if (take && in_sof) begin
            synced <= 1'b1;
         end
         // sof restarts at zero, so the following pixel goes to one
         if (keep) begin
            next_addr <= in_sof ? video_pkg::store_addr_t'(1) : next_addr + 1'b1;
         end
      end
   end

   // one-entry output register feeding the store
   always_ff @(posedge clk) begin
      if (keep) begin
         wr.data <= in_data;
         wr.addr <= in_sof ? '0 : next_addr;
      end
   end

endmodule

// ==== rtl/video_timing.sv ====
// raster timing generator: pixel and line counters, hsync, vsync and blank
`timescale 1ns/1ps

module video_timing #(
   parameter int H_ACTIVE = 32,
   parameter int H_FRONT = 2,
   parameter int H_SYNC = 4,
   parameter int H_BACK = 2,
   parameter int V_ACTIVE = 24,
   parameter int V_FRONT = 2,
   parameter int V_SYNC = 2,
   parameter int V_BACK = 2,
   localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK,
   localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK,
   localparam int H_W = $clog2(H_TOTAL),
   localparam int V_W = $clog2(V_TOTAL)
) (
   input  logic           clk,
   input  logic           rst_n,
   output logic [H_W-1:0] hcount,
   output logic [V_W-1:0] vcount,
   output logic           hsync,
   output logic           vsync,
   output logic           blank
);

   // compare points, all taken one count early so the
   // registered flags line up with the new counter values
   logic hblank_on, hsync_on, hsync_off, h_wrap;
   logic vblank_on, vsync_on, vsync_off, v_wrap;
   logic hblank, vblank;
   logic hblank_nxt, vblank_nxt;

   assign hblank_on = (hcount == H_W'(H_ACTIVE - 1));
   assign hsync_on  = (hcount == H_W'(H_ACTIVE + H_FRONT - 1));
   assign hsync_off = (hcount == H_W'(H_ACTIVE + H_FRONT + H_SYNC - 1));
   assign h_wrap    = (hcount == H_W'(H_TOTAL - 1));

   // vertical events only fire at the end of a line
   assign vblank_on = h_wrap && (vcount == V_W'(V_ACTIVE - 1));
   assign vsync_on  = h_wrap && (vcount == V_W'(V_ACTIVE + V_FRONT - 1));
   assign vsync_off = h_wrap && (vcount == V_W'(V_ACTIVE + V_FRONT + V_SYNC - 1));
   assign v_wrap    = h_wrap && (vcount == V_W'(V_TOTAL - 1));

   assign hblank_nxt = h_wrap ? 1'b0 : (hblank_on ? 1'b1 : hblank);
   assign vblank_nxt = v_wrap ? 1'b0 : (vblank_on ? 1'b1 : vblank);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hcount <= '0;
         vcount <= '0;
         hblank <= 1'b0;
         vblank <= 1'b0;
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         blank  <= 1'b0;
      end else begin
         hcount <= h_wrap ? '0 : hcount + 1'b1;
         if (h_wrap) begin
            vcount <= v_wrap ? '0 : vcount + 1'b1;
         end
         hblank <= hblank_nxt;
         vblank <= vblank_nxt;
         // syncs are active low
         hsync  <= hsync_on ? 1'b0 : (hsync_off ? 1'b1 : hsync);
         vsync  <= vsync_on ? 1'b0 : (vsync_off ? 1'b1 : vsync);
         blank  <= hblank_nxt || vblank_nxt;
      end
   end

endmodule

// ==== rtl/store_wr_if.sv ====
// frame store write port interface with writer and store modports
`timescale 1ns/1ps

interface store_wr_if;
   // handshake, write happens when both are high
   logic valid;
   logic ready;
   // payload, held stable until the handshake
   video_pkg::store_addr_t addr;
   video_pkg::pix_t data;

   // capture side
   modport writer (output valid, output addr, output data, input ready);

   // memory side
   modport store (input valid, input addr, input data, output ready);
endinterface

// ==== rtl/video_pkg.sv ====
// pixel, store address and phase types, display levels and fetch latency
package video_pkg;

   ////////////////////////////////////////
   // types
   ////////////////////////////////////////

   // one luma sample, one store word
   typedef logic [7:0] pix_t;

   // frame store address
   // 7 bits covers the 16 x 8 image window
   typedef logic [6:0] store_addr_t;

   // capture fills the store, show displays it
   typedef enum logic {
      capture,
      show
   } phase_e;

   ////////////////////////////////////////
   // display constants
   ////////////////////////////////////////

   // mid-gray around the image window
   localparam pix_t BG_LEVEL = 8'h80;

   // blanking and capture phase output
   localparam pix_t BLACK_LEVEL = 8'h00;

   // raster position to pixel ready
   // one clock of store read, one clock of output select register
   localparam int FETCH_LAT = 2;

endpackage
